// ==== sources.f ====
source/instBufferPkg.sv
source/bufWriteIf.sv
source/laneCompactor.sv
source/instBufferRam.sv
source/instBufferCtrl.sv
source/dispatchLatch.sv
source/instBuffer.sv
test/clockGen.sv
test/instBufferTb.sv

// ==== Bender.yml ====
package:
  name: instBuffer

sources:
  - files:
      - source/instBufferPkg.sv
      - source/bufWriteIf.sv
      - source/laneCompactor.sv
      - source/instBufferRam.sv
      - source/instBufferCtrl.sv
      - source/dispatchLatch.sv
      - source/instBuffer.sv
  - target: test
    files:
      - test/clockGen.sv
      - test/instBufferTb.sv

// ==== test/instBufferTb.sv ====
module instBufferTb;
  import instBufferPkg::*;

  // generous estimate of the cycles that all tests take together.
  localparam int TEST_CYCLES = 600;
  localparam int WATCHDOG_TIME = TEST_CYCLES * 4 * 2;

  logic clk;
  logic rst;
  logic flush;
  logic fetchValid;
  laneMask_t fetchLaneMask;
  instPacket_t drvPkt [FETCH_WIDTH];
  logic fetchReady;
  logic dispatchValid;
  logic dispatchReady;
  instPacket_t dispatchPacket0;
  instPacket_t dispatchPacket1;
  branchCount_t branchCount;

  // lanes of the next group, copied to the DUT on the falling edge.
  instPacket_t stagePkt [FETCH_WIDTH];
  // accepted packets, oldest first.
  instPacket_t expQ [$];
  int errors = 0;
  int checks = 0;
  int seqNum = 0;
  integer seed = 32'hc52f7e9d;
  string testName = "reset";
  logic accepted = 1'b0;
  // group seen stalled at the previous sample.
  logic held = 1'b0;
  instPacket_t heldPkt0;
  instPacket_t heldPkt1;
  branchCount_t heldBranches;
  // dispatched groups per branch count.
  int seenBranches [4];

  clockGen u_clk (
    .clk_o (clk),
    .rst_o (rst)
  );

  instBuffer u_dut (
    .clk               (clk),
    .rst_i             (rst),
    .flush_i           (flush),
    .fetchValid_i      (fetchValid),
    .fetchLaneMask_i   (fetchLaneMask),
    .fetchPacket0_i    (drvPkt[0]),
    .fetchPacket1_i    (drvPkt[1]),
    .fetchPacket2_i    (drvPkt[2]),
    .fetchPacket3_i    (drvPkt[3]),
    .fetchReady_o      (fetchReady),
    .dispatchValid_o   (dispatchValid),
    .dispatchReady_i   (dispatchReady),
    .dispatchPacket0_o (dispatchPacket0),
    .dispatchPacket1_o (dispatchPacket1),
    .branchCount_o     (branchCount)
  );

  task automatic comparePacket(input string what, input instPacket_t expected,
                               input instPacket_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: %s expected %h actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic compareBranchCount(input string what, input branchCount_t expected,
                                    input branchCount_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: %s expected %0d actual %0d", testName, what, expected, actual);
    end
  endtask

  task automatic compareBit(input string what, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: %s expected %b actual %b", testName, what, expected, actual);
    end
  endtask

  task automatic reportFailure(input string what);
    errors++;
    $display("%s: %s", testName, what);
  endtask

  // numbered packets, so a dropped or reordered lane shows up.
  task automatic stageGroup(input laneMask_t branchMask);
    for (int lane = 0; lane < FETCH_WIDTH; lane++) begin
      stagePkt[lane] = {branchMask[lane], 7'd0, 24'(seqNum)};
      seqNum++;
    end
  endtask

  // called mid cycle, where all inputs and outputs are settled.
  task automatic sampleCycle();
    branchCount_t expBranches;
    // a stalled group must not move.
    if (held) begin
      compareBit("dispatchValid_o under stall", 1'b1, dispatchValid);
      comparePacket("packet0 under stall", heldPkt0, dispatchPacket0);
      comparePacket("packet1 under stall", heldPkt1, dispatchPacket1);
      compareBranchCount("branchCount_o under stall", heldBranches, branchCount);
    end
    if (dispatchValid && dispatchReady) begin
      if (expQ.size() < 2) begin
        reportFailure("a group came out that was never accepted");
      end else begin
        expBranches = branchCount_t'(expQ[0][BRANCH_BIT]) + branchCount_t'(expQ[1][BRANCH_BIT]);
        comparePacket("dispatchPacket0_o", expQ[0], dispatchPacket0);
        comparePacket("dispatchPacket1_o", expQ[1], dispatchPacket1);
        compareBranchCount("branchCount_o", expBranches, branchCount);
        seenBranches[branchCount]++;
        void'(expQ.pop_front());
        void'(expQ.pop_front());
      end
    end
    held = dispatchValid && !dispatchReady && !flush;
    heldPkt0 = dispatchPacket0;
    heldPkt1 = dispatchPacket1;
    heldBranches = branchCount;
    // valid lanes enter in lane order, masked lanes are dropped.
    accepted = fetchValid && fetchReady && !flush;
    if (accepted) begin
      for (int lane = 0; lane < FETCH_WIDTH; lane++) begin
        if (fetchLaneMask[lane]) expQ.push_back(drvPkt[lane]);
      end
    end
    if (flush) expQ.delete();
  endtask

  task automatic runCycle(input logic valid, input laneMask_t mask, input logic ready,
                          input logic doFlush);
    @(negedge clk);
    fetchValid = valid;
    fetchLaneMask = mask;
    dispatchReady = ready;
    flush = doFlush;
    for (int lane = 0; lane < FETCH_WIDTH; lane++) drvPkt[lane] = stagePkt[lane];
    #1;
    sampleCycle();
  endtask

  task automatic idleCycle(input logic ready);
    runCycle(1'b0, '0, ready, 1'b0);
  endtask

  // holds the group on the bus until the buffer takes it.
  task automatic offerGroup(input laneMask_t mask, input laneMask_t branchMask,
                            input logic ready);
    int tries;
    tries = 0;
    stageGroup(branchMask);
    do begin
      runCycle(1'b1, mask, ready, 1'b0);
      tries++;
    end while (!accepted && tries < 40);
    if (!accepted) reportFailure("a fetch group was never accepted");
  endtask

  // rename takes groups until fewer than two packets remain.
  task automatic drain();
    int cycles;
    cycles = 0;
    while ((expQ.size() >= 2 || dispatchValid) && cycles < 60) begin
      idleCycle(1'b1);
      cycles++;
    end
    if (expQ.size() >= 2 || dispatchValid) begin
      reportFailure($sformatf("buffer did not drain, %0d packets still expected", expQ.size()));
    end
  endtask

  task automatic testReset();
    testName = "reset";
    compareBit("dispatchValid_o after reset", 1'b0, dispatchValid);
    compareBit("fetchReady_o after reset", 1'b1, fetchReady);
  endtask

  task automatic testSparse();
    testName = "sparse";
    offerGroup(4'b1010, '0, 1'b0);
    idleCycle(1'b0);
    // the store holds the pair, the latch has not loaded it yet.
    compareBit("dispatchValid_o before the latch loads", 1'b0, dispatchValid);
    idleCycle(1'b0);
    // empty buffer, so the group shows one edge after the accept.
    compareBit("dispatchValid_o one edge after accept", 1'b1, dispatchValid);
    offerGroup(4'b0001, '0, 1'b1);
    drain();
    // one packet left, it needs a partner.
    repeat (4) begin
      idleCycle(1'b1);
      compareBit("lone packet held back", 1'b0, dispatchValid);
    end
    offerGroup(4'b0100, '0, 1'b1);
    offerGroup(4'b1001, '0, 1'b1);
    offerGroup(4'b0000, '0, 1'b1);
    offerGroup(4'b0111, '0, 1'b1);
    offerGroup(4'b1000, '0, 1'b1);
    drain();
    if (expQ.size() != 0) reportFailure("packets left behind after sparse groups");
  endtask

  task automatic testBranch();
    testName = "branch";
    foreach (seenBranches[i]) seenBranches[i] = 0;
    offerGroup(4'b1111, 4'b0000, 1'b1);
    offerGroup(4'b1111, 4'b0011, 1'b1);
    offerGroup(4'b1111, 4'b1001, 1'b1);
    offerGroup(4'b1111, 4'b1100, 1'b1);
    offerGroup(4'b1111, 4'b0110, 1'b1);
    drain();
    for (int i = 0; i <= DISPATCH_WIDTH; i++) begin
      if (seenBranches[i] == 0) reportFailure($sformatf("no group with %0d branches", i));
    end
  endtask

  task automatic testBackPressure();
    int cycles;
    testName = "backpressure";
    cycles = 0;
    // rename stalls while full groups keep arriving.
    do begin
      stageGroup(4'b0101);
      runCycle(1'b1, 4'b1111, 1'b0, 1'b0);
      cycles++;
    end while (fetchReady && cycles < 20);
    if (fetchReady) reportFailure("fetchReady_o never fell while rename stalled");
    repeat (6) begin
      stageGroup(4'b1010);
      runCycle(1'b1, 4'b1111, 1'b0, 1'b0);
    end
    drain();
    if (expQ.size() != 0) reportFailure("packets left behind after back-pressure");
  endtask

  task automatic testFlush();
    testName = "flush";
    offerGroup(4'b1111, 4'b0010, 1'b0);
    offerGroup(4'b0111, 4'b0000, 1'b0);
    idleCycle(1'b0);
    // the group beside the flush is on the wrong path.
    stageGroup(4'b0000);
    runCycle(1'b1, 4'b1111, 1'b0, 1'b1);
    idleCycle(1'b1);
    compareBit("dispatchValid_o after flush", 1'b0, dispatchValid);
    compareBit("fetchReady_o after flush", 1'b1, fetchReady);
    offerGroup(4'b0011, 4'b0001, 1'b1);
    offerGroup(4'b1100, 4'b1000, 1'b1);
    drain();
    if (expQ.size() != 0) reportFailure("packets left behind after flush");
  endtask

  task automatic testRandom();
    logic [31:0] rnd;
    testName = "random";
    repeat (300) begin
      for (int lane = 0; lane < FETCH_WIDTH; lane++) stagePkt[lane] = $random(seed);
      rnd = $random(seed);
      // ready three times in four, a flush now and then.
      runCycle(rnd[0], rnd[7:4], rnd[9:8] != 2'b00, rnd[15:10] == 6'd0);
    end
    drain();
  endtask

  initial begin
    flush = 1'b0;
    fetchValid = 1'b0;
    fetchLaneMask = '0;
    dispatchReady = 1'b0;
    for (int lane = 0; lane < FETCH_WIDTH; lane++) begin
      drvPkt[lane] = '0;
      stagePkt[lane] = '0;
    end
    wait (!rst);
    @(negedge clk);
    #1;
    testReset();
    testSparse();
    testBranch();
    testBackPressure();
    testFlush();
    testRandom();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // ends a run that hangs on a missing handshake.
  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== test/clockGen.sv ====
module clockGen (
  output logic clk_o,
  output logic rst_o
);

  // period of 4, two units high and two low.
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset spans the first two rising edges.
  // it drops on a falling edge, like every other stimulus.
  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// ==== source/instBuffer.sv ====
module instBuffer (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic                        flush_i,
  input  logic                        fetchValid_i,
  input  instBufferPkg::laneMask_t    fetchLaneMask_i,
  input  instBufferPkg::instPacket_t  fetchPacket0_i,
  input  instBufferPkg::instPacket_t  fetchPacket1_i,
  input  instBufferPkg::instPacket_t  fetchPacket2_i,
  input  instBufferPkg::instPacket_t  fetchPacket3_i,
  output logic                        fetchReady_o,
  output logic                        dispatchValid_o,
  input  logic                        dispatchReady_i,
  output instBufferPkg::instPacket_t  dispatchPacket0_o,
  output instBufferPkg::instPacket_t  dispatchPacket1_o,
  output instBufferPkg::branchCount_t branchCount_o
);
  import instBufferPkg::*;

  // write permit from the controller to the compactor.
  logic accept;

  // packets written this cycle, fed back to move the tail.
  laneCount_t writeCount;

  // store pointers.
  queuePtr_t tailPtr;
  queuePtr_t headPtr;

  // handshake between the controller and the output latch.
  logic canLoad;
  logic load;

  // oldest two entries of the store.
  instPacket_t readPacket0;
  instPacket_t readPacket1;

  // write ports from the compactor into the store.
  bufWriteIf wrBus ();

  // occupancy, pointers and the group move decision.
  instBufferCtrl u_ctrl (
    .clk          (clk),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .fetchValid_i (fetchValid_i),
    .fetchReady_o (fetchReady_o),
    .writeCount_i (writeCount),
    .accept_o     (accept),
    .tailPtr_o    (tailPtr),
    .headPtr_o    (headPtr),
    .canLoad_i    (canLoad),
    .load_o       (load)
  );

  // packs valid lanes into consecutive entries.
  laneCompactor u_compactor (
    .accept_i       (accept),
    .laneMask_i     (fetchLaneMask_i),
    .tailPtr_i      (tailPtr),
    .fetchPacket0_i (fetchPacket0_i),
    .fetchPacket1_i (fetchPacket1_i),
    .fetchPacket2_i (fetchPacket2_i),
    .fetchPacket3_i (fetchPacket3_i),
    .wr             (wrBus.writer),
    .writeCount_o   (writeCount)
  );

  // circular packet store.
  instBufferRam u_ram (
    .clk           (clk),
    .wr            (wrBus.store),
    .headPtr_i     (headPtr),
    .readPacket0_o (readPacket0),
    .readPacket1_o (readPacket1)
  );

  // registered dispatch group toward rename.
  dispatchLatch u_latch (
    .clk               (clk),
    .rst_i             (rst_i),
    .flush_i           (flush_i),
    .load_i            (load),
    .readPacket0_i     (readPacket0),
    .readPacket1_i     (readPacket1),
    .canLoad_o         (canLoad),
    .dispatchValid_o   (dispatchValid_o),
    .dispatchReady_i   (dispatchReady_i),
    .dispatchPacket0_o (dispatchPacket0_o),
    .dispatchPacket1_o (dispatchPacket1_o),
    .branchCount_o     (branchCount_o)
  );

endmodule

// ==== source/dispatchLatch.sv ====
module dispatchLatch (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic                        flush_i,
  input  logic                        load_i,
  input  instBufferPkg::instPacket_t  readPacket0_i,
  input  instBufferPkg::instPacket_t  readPacket1_i,
  output logic                        canLoad_o,
  output logic                        dispatchValid_o,
  input  logic                        dispatchReady_i,
  output instBufferPkg::instPacket_t  dispatchPacket0_o,
  output instBufferPkg::instPacket_t  dispatchPacket1_o,
  output instBufferPkg::branchCount_t branchCount_o
);
  import instBufferPkg::*;

  // latch holds a group.
  logic groupValid;

  // registered group and its branch count.
  instPacket_t packet0;
  instPacket_t packet1;
  branchCount_t branchCount;

  // rename takes the group on this edge.
  logic take;

  // branch count of the group being read from the store.
  branchCount_t loadBranches;

  assign take = groupValid & dispatchReady_i;

  // free now, or freed by the take on this same edge.
  assign canLoad_o = ~groupValid | dispatchReady_i;

  assign loadBranches = branchCount_t'(readPacket0_i[BRANCH_BIT])
                      + branchCount_t'(readPacket1_i[BRANCH_BIT]);

  // a load wins over a take, so back-to-back groups stream.
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      groupValid <= 1'b0;
    end else if (load_i) begin
      groupValid <= 1'b1;
    end else if (take) begin
      groupValid <= 1'b0;
    end
  end

  // payload only moves on a load.
  always_ff @(posedge clk) begin
    if (load_i) begin
      packet0 <= readPacket0_i;
      packet1 <= readPacket1_i;
      branchCount <= loadBranches;
    end
  end

  assign dispatchValid_o = groupValid;
  assign dispatchPacket0_o = packet0;
  assign dispatchPacket1_o = packet1;
  assign branchCount_o = branchCount;

  // a stalled group stays put until rename takes it.
  // this relies on the controller never loading while canLoad_o is low.
  holdWhileStalled : assert property (
    @(posedge clk) disable iff (rst_i)
    (dispatchValid_o && !dispatchReady_i && !flush_i) |=>
      (dispatchValid_o && $stable(dispatchPacket0_o) &&
       $stable(dispatchPacket1_o) && $stable(branchCount_o))
  );

endmodule

// ==== source/instBufferCtrl.sv ====
module instBufferCtrl (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      flush_i,
  input  logic                      fetchValid_i,
  output logic                      fetchReady_o,
  input  instBufferPkg::laneCount_t writeCount_i,
  output logic                      accept_o,
  output instBufferPkg::queuePtr_t  tailPtr_o,
  output instBufferPkg::queuePtr_t  headPtr_o,
  input  logic                      canLoad_i,
  output logic                      load_o
);
  import instBufferPkg::*;

  // oldest entry, read by dispatch.
  queuePtr_t headPtr;

  // first free entry, written by fetch.
  queuePtr_t tailPtr;

  // occupied entries.
  queueCount_t count;
  queueCount_t countNext;

  // entries added and removed this cycle.
  queueCount_t countIn;
  queueCount_t countOut;

  // room for a full decode group, whatever its mask.
  // taken from the count alone so it does not wait on fetchValid_i.
  assign fetchReady_o = (count <= queueCount_t'(QUEUE_DEPTH - FETCH_WIDTH));

  // a group offered alongside a flush belongs to the wrong path.
  assign accept_o = fetchValid_i & fetchReady_o & ~flush_i;

  // move a group to the latch once two entries wait and it has room.
  assign load_o = (count >= queueCount_t'(DISPATCH_WIDTH)) & canLoad_i;

  assign countIn = queueCount_t'(writeCount_i);
  assign countOut = load_o ? queueCount_t'(DISPATCH_WIDTH) : '0;

  // writes and a load can land on the same edge.
  assign countNext = count + countIn - countOut;

  // pointers and count restart at zero on a flush.
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      headPtr <= '0;
      tailPtr <= '0;
      count <= '0;
    end else begin
      if (load_o) begin
        headPtr <= headPtr + queuePtr_t'(DISPATCH_WIDTH);
      end
      tailPtr <= tailPtr + queuePtr_t'(writeCount_i);
      count <= countNext;
    end
  end

  assign tailPtr_o = tailPtr;
  assign headPtr_o = headPtr;

  // the ready threshold must keep the store from overflowing,
  // even with a full group and no load.
  countInRange : assert property (
    @(posedge clk) disable iff (rst_i)
    count <= queueCount_t'(QUEUE_DEPTH)
  );

  // a load reads two entries, so both must hold real packets.
  loadHasPair : assert property (
    @(posedge clk) disable iff (rst_i)
    load_o |-> (count >= queueCount_t'(DISPATCH_WIDTH))
  );

endmodule

// ==== source/instBufferRam.sv ====
module instBufferRam (
  input  logic                       clk,
  bufWriteIf.store                   wr,
  input  instBufferPkg::queuePtr_t   headPtr_i,
  output instBufferPkg::instPacket_t readPacket0_o,
  output instBufferPkg::instPacket_t readPacket1_o
);
  import instBufferPkg::*;

  // packet storage, indexed by queue pointer.
  instPacket_t mem [QUEUE_DEPTH];

  // the second dispatch slot sits one entry past the head.
  queuePtr_t nextPtr;

  // four independent write ports.
  always_ff @(posedge clk) begin
    for (int port = 0; port < FETCH_WIDTH; port++) begin
      if (wr.writeEn[port]) begin
        mem[wr.writeAddr[port]] <= wr.writePacket[port];
      end
    end
  end

  // wraps from the last entry back to entry zero.
  assign nextPtr = headPtr_i + queuePtr_t'(1);

  // combinational read of the oldest two entries.
  assign readPacket0_o = mem[headPtr_i];
  assign readPacket1_o = mem[nextPtr];

  // the compactor must hand each enabled port its own entry.
  // a collision would silently drop one packet of the group.
  for (genvar portA = 0; portA < FETCH_WIDTH; portA++) begin : gPortA
    for (genvar portB = portA + 1; portB < FETCH_WIDTH; portB++) begin : gPortB
      writeAddrUnique : assert property (
        @(posedge clk)
        (wr.writeEn[portA] && wr.writeEn[portB]) |->
          (wr.writeAddr[portA] != wr.writeAddr[portB])
      );
    end
  end

endmodule

// ==== source/laneCompactor.sv ====
module laneCompactor (
  input  logic                       accept_i,
  input  instBufferPkg::laneMask_t   laneMask_i,
  input  instBufferPkg::queuePtr_t   tailPtr_i,
  input  instBufferPkg::instPacket_t fetchPacket0_i,
  input  instBufferPkg::instPacket_t fetchPacket1_i,
  input  instBufferPkg::instPacket_t fetchPacket2_i,
  input  instBufferPkg::instPacket_t fetchPacket3_i,
  bufWriteIf.writer                  wr,
  output instBufferPkg::laneCount_t  writeCount_o
);
  import instBufferPkg::*;

  // fetch packets gathered so the lanes can be walked in a loop.
  instPacket_t lanePacket [FETCH_WIDTH];

  // number of set bits in the whole mask.
  laneCount_t maskCount;

  assign lanePacket[0] = fetchPacket0_i;
  assign lanePacket[1] = fetchPacket1_i;
  assign lanePacket[2] = fetchPacket2_i;
  assign lanePacket[3] = fetchPacket3_i;

  // each lane lands at the tail plus the count of valid lanes below it.
  // the pointer add wraps naturally at QUEUE_DEPTH.
  always_comb begin
    laneCount_t running;
    running = '0;
    for (int lane = 0; lane < FETCH_WIDTH; lane++) begin
      wr.writeAddr[lane] = tailPtr_i + queuePtr_t'(running);
      wr.writePacket[lane] = lanePacket[lane];
      running = running + laneCount_t'(laneMask_i[lane]);
    end
    maskCount = running;
  end

  // masked-off lanes never write, so their slot value is a don't care.
  // Valid lanes get distinct consecutive slots, which packs the group.
  assign wr.writeEn = accept_i ? laneMask_i : '0;

  // the tail moves by the number of packets actually written.
  assign writeCount_o = accept_i ? maskCount : '0;

endmodule

// ==== source/bufWriteIf.sv ====
interface bufWriteIf;
  import instBufferPkg::*;

  // one write port per fetch lane.
  logic [FETCH_WIDTH-1:0] writeEn;

  // target entry of each port.
  queuePtr_t writeAddr [FETCH_WIDTH];

  // packet carried by each port.
  instPacket_t writePacket [FETCH_WIDTH];

  // the compactor drives the ports.
  modport writer (
    output writeEn,
    output writeAddr,
    output writePacket
  );

  // the store samples them on the clock edge.
  modport store (
    input writeEn,
    input writeAddr,
    input writePacket
  );

endinterface

// ==== source/instBufferPkg.sv ====
package instBufferPkg;

  // lanes in one decode group.
  localparam int FETCH_WIDTH = 4;

  // packets handed to rename per dispatch group.
  localparam int DISPATCH_WIDTH = 2;

  // entries in the circular store and the pointer width that addresses them.
  localparam int QUEUE_DEPTH = 16;
  localparam int QUEUE_LOG = 4;

  // decoded packet width and the position of its branch flag.
  localparam int PACKET_WIDTH = 32;
  localparam int BRANCH_BIT = 31;

  // counter widths, sized to hold the full range of each count.
  localparam int LANE_COUNT_WIDTH = 3;
  localparam int BRANCH_COUNT_WIDTH = 2;

  // one decoded instruction packet.
  typedef logic [PACKET_WIDTH-1:0] instPacket_t;

  // entry address inside the store.
  typedef logic [QUEUE_LOG-1:0] queuePtr_t;

  // occupied entries, 0 up to QUEUE_DEPTH inclusive.
  typedef logic [QUEUE_LOG:0] queueCount_t;

  // valid lanes of a decode group, bit n for lane n.
  typedef logic [FETCH_WIDTH-1:0] laneMask_t;

  // a number of lanes, 0 to FETCH_WIDTH.
  typedef logic [LANE_COUNT_WIDTH-1:0] laneCount_t;

  // branches in one dispatch group, 0 to DISPATCH_WIDTH.
  typedef logic [BRANCH_COUNT_WIDTH-1:0] branchCount_t;

endpackage
